/* verilog/cache_pkg.sv */
package cache_pkg;

   // front-end geometry
   localparam int FE_ADDR_W = 16;
   localparam int FE_DATA_W = 32;
   localparam int NBYTES    = 4;
   localparam int NBYTES_W  = 2;

   // cache geometry, four words per line and 16 lines
   localparam int WORD_OFFSET_W = 2;
   localparam int NLINES_W      = 4;
   localparam int TAG_W         = FE_ADDR_W - NBYTES_W - WORD_OFFSET_W - NLINES_W;
   localparam int WTBUF_DEPTH_W = 2;

   // control register map
   localparam int CTRL_ADDR_W = 3;
   localparam logic [CTRL_ADDR_W-1:0] REG_RD_HIT     = 3'd0;
   localparam logic [CTRL_ADDR_W-1:0] REG_RD_MISS    = 3'd1;
   localparam logic [CTRL_ADDR_W-1:0] REG_WR_HIT     = 3'd2;
   localparam logic [CTRL_ADDR_W-1:0] REG_WR_MISS    = 3'd3;
   localparam logic [CTRL_ADDR_W-1:0] REG_WTB_EMPTY  = 3'd4;
   localparam logic [CTRL_ADDR_W-1:0] REG_WTB_FULL   = 3'd5;
   localparam logic [CTRL_ADDR_W-1:0] REG_INVALIDATE = 3'd6;

   typedef logic [FE_DATA_W-1:0]          fe_data_t;
   typedef logic [NBYTES-1:0]             fe_strb_t;
   typedef logic [FE_ADDR_W-NBYTES_W-1:0] word_addr_t;
   // top bit selects the control space
   typedef logic [FE_ADDR_W-NBYTES_W:0]   fe_req_addr_t;
   typedef logic [TAG_W-1:0]              tag_t;
   typedef logic [NLINES_W-1:0]           index_t;
   typedef logic [WORD_OFFSET_W-1:0]      offset_t;

endpackage

/* verilog/cache_front_end.sv */
`timescale 1ns/1ps

module cache_front_end
   import cache_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   req_i,
   input  fe_req_addr_t           addr_i,
   input  fe_data_t               wdata_i,
   input  fe_strb_t               wstrb_i,
   output fe_data_t               rdata_o,
   output logic                   ack_o,
   output logic                   data_req_o,
   output word_addr_t             data_addr_o,
   output fe_data_t               data_wdata_o,
   output fe_strb_t               data_wstrb_o,
   input  fe_data_t               data_rdata_i,
   input  logic                   data_ack_i,
   output logic                   ctrl_req_o,
   output logic [CTRL_ADDR_W-1:0] ctrl_addr_o,
   output logic                   ctrl_write_o,
   input  fe_data_t               ctrl_rdata_i,
   input  logic                   ctrl_ack_i
);

   logic         busy;
   logic         sel_ctrl;
   fe_req_addr_t addr_q;
   fe_data_t     wdata_q;
   fe_strb_t     wstrb_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy <= 1'b0;
      end else if (!busy && req_i) begin
         busy <= 1'b1;
      end else if (ack_o) begin
         busy <= 1'b0;
      end
   end

   // request copy, only loaded when idle
   always_ff @(posedge clk_i) begin
      if (!busy && req_i) begin
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end
   end

   assign sel_ctrl = addr_q[FE_ADDR_W-NBYTES_W];

   assign data_req_o   = busy && !sel_ctrl;
   assign data_addr_o  = addr_q[FE_ADDR_W-NBYTES_W-1:0];
   assign data_wdata_o = wdata_q;
   assign data_wstrb_o = wstrb_q;

   assign ctrl_req_o   = busy && sel_ctrl;
   assign ctrl_addr_o  = addr_q[CTRL_ADDR_W-1:0];
   assign ctrl_write_o = |wstrb_q;

   // each side acks once per request
   assign ack_o   = data_ack_i | ctrl_ack_i;
   assign rdata_o = sel_ctrl ? ctrl_rdata_i : data_rdata_i;

   a_single_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_o |=> !ack_o);

endmodule

/* verilog/cache_memory.sv */
`timescale 1ns/1ps

module cache_memory
   import cache_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       req_i,
   input  word_addr_t addr_i,
   input  fe_data_t   wdata_i,
   input  fe_strb_t   wstrb_i,
   output fe_data_t   rdata_o,
   output logic       ack_o,
   input  logic       wtb_full_i,
   input  logic       wtb_empty_i,
   output logic       wtb_push_o,
   output word_addr_t wtb_addr_o,
   output fe_data_t   wtb_data_o,
   output fe_strb_t   wtb_strb_o,
   output logic       refill_req_o,
   output word_addr_t refill_addr_o,
   input  logic       refill_valid_i,
   input  offset_t    refill_offset_i,
   input  fe_data_t   refill_data_i,
   input  logic       refill_done_i,
   input  logic       invalidate_all_i,
   output logic       rd_hit_o,
   output logic       rd_miss_o,
   output logic       wr_hit_o,
   output logic       wr_miss_o
);

   typedef enum logic [1:0] {S_IDLE, S_WAIT, S_REFILL} state_t;

   state_t                 state;
   tag_t                   tag_mem  [2**NLINES_W];
   fe_data_t               data_mem [2**(NLINES_W+WORD_OFFSET_W)];
   logic [2**NLINES_W-1:0] valid;

   tag_t    req_tag;
   index_t  req_idx;
   offset_t req_off;
   logic    is_write;
   logic    hit;
   logic    new_req;
   logic    wr_go;
   logic    rd_hit_go;

   assign {req_tag, req_idx, req_off} = addr_i;

   assign is_write = |wstrb_i;
   assign hit      = valid[req_idx] && (tag_mem[req_idx] == req_tag);
   // still unserved until our own ack has gone out
   assign new_req   = (state == S_IDLE) && req_i && !ack_o;
   assign wr_go     = new_req && is_write && !wtb_full_i;
   assign rd_hit_go = new_req && !is_write && hit;

   assign refill_addr_o = {req_tag, req_idx, {WORD_OFFSET_W{1'b0}}};

   // front end keeps its request registers stable past the ack
   assign wtb_addr_o = addr_i;
   assign wtb_data_o = wdata_i;
   assign wtb_strb_o = wstrb_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state        <= S_IDLE;
         ack_o        <= 1'b0;
         wtb_push_o   <= 1'b0;
         refill_req_o <= 1'b0;
         valid        <= '0;
         rd_hit_o     <= 1'b0;
         rd_miss_o    <= 1'b0;
         wr_hit_o     <= 1'b0;
         wr_miss_o    <= 1'b0;
      end else begin
         ack_o      <= 1'b0;
         wtb_push_o <= 1'b0;
         rd_hit_o   <= 1'b0;
         rd_miss_o  <= 1'b0;
         wr_hit_o   <= 1'b0;
         wr_miss_o  <= 1'b0;
         case (state)
            S_IDLE: begin
               // writes always go through, a full buffer just stalls them
               if (wr_go) begin
                  ack_o      <= 1'b1;
                  wtb_push_o <= 1'b1;
                  wr_hit_o   <= hit;
                  wr_miss_o  <= !hit;
               end else if (rd_hit_go) begin
                  ack_o    <= 1'b1;
                  rd_hit_o <= 1'b1;
               end else if (new_req && !is_write) begin
                  rd_miss_o <= 1'b1;
                  state     <= S_WAIT;
               end
            end
            S_WAIT: begin
               if (wtb_empty_i) begin
                  refill_req_o <= 1'b1;
                  state        <= S_REFILL;
               end
            end
            S_REFILL: begin
               if (refill_done_i) begin
                  refill_req_o   <= 1'b0;
                  valid[req_idx] <= 1'b1;
                  ack_o          <= 1'b1;
                  state          <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
         if (invalidate_all_i) begin
            valid <= '0;
         end
      end
   end

   // arrays and read data
   always_ff @(posedge clk_i) begin
      if (refill_valid_i) begin
         data_mem[{req_idx, refill_offset_i}] <= refill_data_i;
      end
      if (wr_go && hit) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (wstrb_i[b]) begin
               data_mem[{req_idx, req_off}][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
      if (state == S_REFILL && refill_done_i) begin
         tag_mem[req_idx] <= req_tag;
         rdata_o          <= data_mem[{req_idx, req_off}];
      end else if (rd_hit_go) begin
         rdata_o <= data_mem[{req_idx, req_off}];
      end
   end

   a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wtb_push_o |-> !wtb_full_i);

endmodule

/* verilog/cache_write_buffer.sv */
`timescale 1ns/1ps

module cache_write_buffer
   import cache_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       push_i,
   input  word_addr_t push_addr_i,
   input  fe_data_t   push_data_i,
   input  fe_strb_t   push_strb_i,
   input  logic       pop_i,
   output word_addr_t head_addr_o,
   output fe_data_t   head_data_o,
   output fe_strb_t   head_strb_o,
   output logic       full_o,
   output logic       empty_o
);

   word_addr_t addr_mem [2**WTBUF_DEPTH_W];
   fe_data_t   data_mem [2**WTBUF_DEPTH_W];
   fe_strb_t   strb_mem [2**WTBUF_DEPTH_W];

   logic [WTBUF_DEPTH_W-1:0] wr_ptr;
   logic [WTBUF_DEPTH_W-1:0] rd_ptr;
   logic [WTBUF_DEPTH_W:0]   count;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + push_i - pop_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         addr_mem[wr_ptr] <= push_addr_i;
         data_mem[wr_ptr] <= push_data_i;
         strb_mem[wr_ptr] <= push_strb_i;
      end
   end

   assign head_addr_o = addr_mem[rd_ptr];
   assign head_data_o = data_mem[rd_ptr];
   assign head_strb_o = strb_mem[rd_ptr];

   assign full_o  = (count == (WTBUF_DEPTH_W+1)'(2**WTBUF_DEPTH_W));
   assign empty_o = (count == '0);

   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> !empty_o);

endmodule

/* verilog/cache_back_end.sv */
`timescale 1ns/1ps

module cache_back_end
   import cache_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 wtb_empty_i,
   input  word_addr_t           wtb_addr_i,
   input  fe_data_t             wtb_data_i,
   input  fe_strb_t             wtb_strb_i,
   output logic                 wtb_pop_o,
   input  logic                 refill_req_i,
   input  word_addr_t           refill_addr_i,
   output logic                 refill_valid_o,
   output offset_t              refill_offset_o,
   output fe_data_t             refill_data_o,
   output logic                 refill_done_o,
   output logic                 be_req_o,
   output logic [FE_ADDR_W-1:0] be_addr_o,
   output fe_data_t             be_wdata_o,
   output fe_strb_t             be_wstrb_o,
   input  fe_data_t             be_rdata_i,
   input  logic                 be_ack_i
);

   typedef enum logic [1:0] {B_IDLE, B_DRAIN, B_REFILL} state_t;

   state_t     state;
   offset_t    cnt;
   word_addr_t be_word;
   logic       start_drain;
   logic       start_refill;

   // drains win, a refill is not restarted while its done pulse is out
   assign start_drain  = (state == B_IDLE) && !wtb_empty_i;
   assign start_refill = (state == B_IDLE) && wtb_empty_i && refill_req_i && !refill_done_o;

   assign be_addr_o = {be_word, {NBYTES_W{1'b0}}};

   // head entry leaves the buffer only once memory has taken it
   assign wtb_pop_o = (state == B_DRAIN) && be_ack_i;

   assign refill_valid_o  = (state == B_REFILL) && be_ack_i;
   assign refill_offset_o = cnt;
   assign refill_data_o   = be_rdata_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state         <= B_IDLE;
         cnt           <= '0;
         be_req_o      <= 1'b0;
         refill_done_o <= 1'b0;
      end else begin
         refill_done_o <= 1'b0;
         case (state)
            B_IDLE: begin
               if (start_drain) begin
                  be_req_o <= 1'b1;
                  state    <= B_DRAIN;
               end else if (start_refill) begin
                  be_req_o <= 1'b1;
                  cnt      <= '0;
                  state    <= B_REFILL;
               end
            end
            B_DRAIN: begin
               if (be_ack_i) begin
                  be_req_o <= 1'b0;
                  state    <= B_IDLE;
               end
            end
            B_REFILL: begin
               if (be_ack_i) begin
                  be_req_o <= 1'b0;
                  cnt      <= cnt + 1'b1;
                  if (&cnt) begin
                     refill_done_o <= 1'b1;
                     state         <= B_IDLE;
                  end
               end else if (!be_req_o) begin
                  // next word of the line
                  be_req_o <= 1'b1;
               end
            end
            default: state <= B_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_drain) begin
         be_word    <= wtb_addr_i;
         be_wdata_o <= wtb_data_i;
         be_wstrb_o <= wtb_strb_i;
      end else if (start_refill) begin
         be_word    <= refill_addr_i;
         be_wstrb_o <= '0;
      end else if (refill_valid_o) begin
         be_word <= be_word + 1'b1;
      end
   end

   a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      be_req_o && !be_ack_i |=> $stable(be_addr_o));

endmodule

/* verilog/cache_control.sv */
`timescale 1ns/1ps

module cache_control
   import cache_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   req_i,
   input  logic [CTRL_ADDR_W-1:0] addr_i,
   input  logic                   write_i,
   output fe_data_t               rdata_o,
   output logic                   ack_o,
   input  logic                   rd_hit_i,
   input  logic                   rd_miss_i,
   input  logic                   wr_hit_i,
   input  logic                   wr_miss_i,
   input  logic                   wtb_full_i,
   input  logic                   wtb_empty_i,
   output logic                   invalidate_all_o,
   input  logic                   invalidate_i,
   output logic                   invalidate_o,
   input  logic                   wtb_empty_chain_i,
   output logic                   wtb_empty_o
);

   fe_data_t rd_hit_cnt;
   fe_data_t rd_miss_cnt;
   fe_data_t wr_hit_cnt;
   fe_data_t wr_miss_cnt;
   logic     inv_q;
   logic     inv_wr;

   // counters stick at the top value
   function automatic fe_data_t sat_inc(input fe_data_t v, input logic ev);
      return (ev && !(&v)) ? v + 1'b1 : v;
   endfunction

   assign inv_wr = req_i && !ack_o && write_i && (addr_i == REG_INVALIDATE);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o       <= 1'b0;
         inv_q       <= 1'b0;
         rd_hit_cnt  <= '0;
         rd_miss_cnt <= '0;
         wr_hit_cnt  <= '0;
         wr_miss_cnt <= '0;
      end else begin
         ack_o <= req_i && !ack_o;
         inv_q <= inv_wr;
         if (inv_wr) begin
            rd_hit_cnt  <= '0;
            rd_miss_cnt <= '0;
            wr_hit_cnt  <= '0;
            wr_miss_cnt <= '0;
         end else begin
            rd_hit_cnt  <= sat_inc(rd_hit_cnt, rd_hit_i);
            rd_miss_cnt <= sat_inc(rd_miss_cnt, rd_miss_i);
            wr_hit_cnt  <= sat_inc(wr_hit_cnt, wr_hit_i);
            wr_miss_cnt <= sat_inc(wr_miss_cnt, wr_miss_i);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      case (addr_i)
         REG_RD_HIT:    rdata_o <= rd_hit_cnt;
         REG_RD_MISS:   rdata_o <= rd_miss_cnt;
         REG_WR_HIT:    rdata_o <= wr_hit_cnt;
         REG_WR_MISS:   rdata_o <= wr_miss_cnt;
         REG_WTB_EMPTY: rdata_o <= fe_data_t'(wtb_empty_i);
         REG_WTB_FULL:  rdata_o <= fe_data_t'(wtb_full_i);
         default:       rdata_o <= '0;
      endcase
   end

   // chain towards neighbouring caches
   assign invalidate_all_o = inv_q | invalidate_i;
   assign invalidate_o     = inv_q | invalidate_i;
   assign wtb_empty_o      = wtb_empty_i & wtb_empty_chain_i;

endmodule

/* verilog/cache_top.sv */
`timescale 1ns/1ps

module cache_top
   import cache_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 req_i,
   input  fe_req_addr_t         addr_i,
   input  fe_data_t             wdata_i,
   input  fe_strb_t             wstrb_i,
   output fe_data_t             rdata_o,
   output logic                 ack_o,
   output logic                 be_req_o,
   output logic [FE_ADDR_W-1:0] be_addr_o,
   output fe_data_t             be_wdata_o,
   output fe_strb_t             be_wstrb_o,
   input  fe_data_t             be_rdata_i,
   input  logic                 be_ack_i,
   input  logic                 invalidate_i,
   output logic                 invalidate_o,
   input  logic                 wtb_empty_i,
   output logic                 wtb_empty_o
);

   logic       data_req, data_ack;
   word_addr_t data_addr;
   fe_data_t   data_wdata, data_rdata;
   fe_strb_t   data_wstrb;

   logic                   ctrl_req, ctrl_ack, ctrl_write;
   logic [CTRL_ADDR_W-1:0] ctrl_addr;
   fe_data_t               ctrl_rdata;

   logic       wtb_push, wtb_pop, wtb_full, wtb_empty;
   word_addr_t wtb_addr, head_addr;
   fe_data_t   wtb_data, head_data;
   fe_strb_t   wtb_strb, head_strb;

   logic       refill_req, refill_valid, refill_done;
   word_addr_t refill_addr;
   offset_t    refill_offset;
   fe_data_t   refill_data;

   logic rd_hit, rd_miss, wr_hit, wr_miss;
   logic invalidate_all;

   cache_front_end front_end (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (req_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .wstrb_i      (wstrb_i),
      .rdata_o      (rdata_o),
      .ack_o        (ack_o),
      .data_req_o   (data_req),
      .data_addr_o  (data_addr),
      .data_wdata_o (data_wdata),
      .data_wstrb_o (data_wstrb),
      .data_rdata_i (data_rdata),
      .data_ack_i   (data_ack),
      .ctrl_req_o   (ctrl_req),
      .ctrl_addr_o  (ctrl_addr),
      .ctrl_write_o (ctrl_write),
      .ctrl_rdata_i (ctrl_rdata),
      .ctrl_ack_i   (ctrl_ack)
   );

   cache_memory cache_memory (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .req_i            (data_req),
      .addr_i           (data_addr),
      .wdata_i          (data_wdata),
      .wstrb_i          (data_wstrb),
      .rdata_o          (data_rdata),
      .ack_o            (data_ack),
      .wtb_full_i       (wtb_full),
      .wtb_empty_i      (wtb_empty),
      .wtb_push_o       (wtb_push),
      .wtb_addr_o       (wtb_addr),
      .wtb_data_o       (wtb_data),
      .wtb_strb_o       (wtb_strb),
      .refill_req_o     (refill_req),
      .refill_addr_o    (refill_addr),
      .refill_valid_i   (refill_valid),
      .refill_offset_i  (refill_offset),
      .refill_data_i    (refill_data),
      .refill_done_i    (refill_done),
      .invalidate_all_i (invalidate_all),
      .rd_hit_o         (rd_hit),
      .rd_miss_o        (rd_miss),
      .wr_hit_o         (wr_hit),
      .wr_miss_o        (wr_miss)
   );

   cache_write_buffer write_buffer (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (wtb_push),
      .push_addr_i (wtb_addr),
      .push_data_i (wtb_data),
      .push_strb_i (wtb_strb),
      .pop_i       (wtb_pop),
      .head_addr_o (head_addr),
      .head_data_o (head_data),
      .head_strb_o (head_strb),
      .full_o      (wtb_full),
      .empty_o     (wtb_empty)
   );

   cache_back_end back_end (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .wtb_empty_i     (wtb_empty),
      .wtb_addr_i      (head_addr),
      .wtb_data_i      (head_data),
      .wtb_strb_i      (head_strb),
      .wtb_pop_o       (wtb_pop),
      .refill_req_i    (refill_req),
      .refill_addr_i   (refill_addr),
      .refill_valid_o  (refill_valid),
      .refill_offset_o (refill_offset),
      .refill_data_o   (refill_data),
      .refill_done_o   (refill_done),
      .be_req_o        (be_req_o),
      .be_addr_o       (be_addr_o),
      .be_wdata_o      (be_wdata_o),
      .be_wstrb_o      (be_wstrb_o),
      .be_rdata_i      (be_rdata_i),
      .be_ack_i        (be_ack_i)
   );

   cache_control cache_control (
      .clk_i             (clk_i),
      .rst_n_i           (rst_n_i),
      .req_i             (ctrl_req),
      .addr_i            (ctrl_addr),
      .write_i           (ctrl_write),
      .rdata_o           (ctrl_rdata),
      .ack_o             (ctrl_ack),
      .rd_hit_i          (rd_hit),
      .rd_miss_i         (rd_miss),
      .wr_hit_i          (wr_hit),
      .wr_miss_i         (wr_miss),
      .wtb_full_i        (wtb_full),
      .wtb_empty_i       (wtb_empty),
      .invalidate_all_o  (invalidate_all),
      .invalidate_i      (invalidate_i),
      .invalidate_o      (invalidate_o),
      .wtb_empty_chain_i (wtb_empty_i),
      .wtb_empty_o       (wtb_empty_o)
   );

endmodule

/* tests/cache_tb_tasks.svh */
function automatic fe_data_t merge_bytes(input fe_data_t old_word, input fe_data_t new_word,
                                         input fe_strb_t strb);
   fe_data_t merged;
   merged = old_word;
   for (int b = 0; b < NBYTES; b++) begin
      if (strb[b]) begin
         merged[8*b +: 8] = new_word[8*b +: 8];
      end
   end
   return merged;
endfunction

// top address bit selects the control registers
function automatic fe_req_addr_t ctrl_space(input logic [CTRL_ADDR_W-1:0] r);
   return {1'b1, {(FE_ADDR_W-NBYTES_W-CTRL_ADDR_W){1'b0}}, r};
endfunction

task automatic check_data(input string name, input fe_data_t expected, input fe_data_t actual);
   check_count++;
   if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
   end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
   check_count++;
   if (actual !== expected) begin
      error_count++;
      $display("ERROR at %0t: %s expected %b, got %b", $time, name, expected, actual);
   end
endtask

task automatic report_timeout(input string what);
   error_count++;
   $display("timeout at %0t while waiting for %s", $time, what);
endtask

task automatic report_result(input string name, input int errors_before);
   $display("test %s finished with %0d errors", name, error_count - errors_before);
endtask

// req held until the one-cycle ack and dropped on the next edge
task automatic issue_request(input fe_req_addr_t a, input fe_data_t d, input fe_strb_t s,
                             output fe_data_t result);
   int waited;
   waited = 0;
   result = '0;
   @(posedge clk);
   req   <= 1'b1;
   addr  <= a;
   wdata <= d;
   wstrb <= s;
   @(negedge clk);
   while (ack !== 1'b1 && waited < REQ_TIMEOUT) begin
      waited++;
      @(negedge clk);
   end
   if (ack !== 1'b1) begin
      report_timeout("ack_o");
   end else begin
      result = rdata;
   end
   @(posedge clk);
   req <= 1'b0;
endtask

task automatic read_word(input word_addr_t a, output fe_data_t result);
   issue_request(fe_req_addr_t'(a), '0, '0, result);
endtask

task automatic write_word(input word_addr_t a, input fe_data_t d, input fe_strb_t s);
   fe_data_t unused;
   issue_request(fe_req_addr_t'(a), d, s, unused);
endtask

task automatic read_ctrl(input logic [CTRL_ADDR_W-1:0] r, output fe_data_t result);
   issue_request(ctrl_space(r), '0, '0, result);
endtask

task automatic write_ctrl(input logic [CTRL_ADDR_W-1:0] r);
   fe_data_t unused;
   issue_request(ctrl_space(r), '0, {NBYTES{1'b1}}, unused);
endtask

task automatic wait_for_writes(input int target);
   int waited;
   waited = 0;
   while (mem_writes < target && waited < REQ_TIMEOUT) begin
      waited++;
      @(negedge clk);
   end
   if (mem_writes < target) begin
      report_timeout("write-through to memory");
   end
endtask

task automatic compare_counters();
   fe_data_t got;
   read_ctrl(REG_RD_HIT, got);
   check_data("rdata_o (REG_RD_HIT)", tally_rd_hit, got);
   read_ctrl(REG_RD_MISS, got);
   check_data("rdata_o (REG_RD_MISS)", tally_rd_miss, got);
   read_ctrl(REG_WR_HIT, got);
   check_data("rdata_o (REG_WR_HIT)", tally_wr_hit, got);
   read_ctrl(REG_WR_MISS, got);
   check_data("rdata_o (REG_WR_MISS)", tally_wr_miss, got);
endtask

task automatic reset_values();
   int errs;
   errs = error_count;
   @(negedge clk);
   check_flag("ack_o", 1'b0, ack);
   check_flag("be_req_o", 1'b0, be_req);
   check_flag("invalidate_o", 1'b0, invalidate_out);
   check_flag("wtb_empty_o", 1'b1, wtb_empty_out);
   report_result("reset values", errs);
endtask

task automatic read_miss_refill();
   int       errs;
   int       reads;
   fe_data_t got;
   errs  = error_count;
   reads = mem_reads;
   read_word(LINE_A, got);
   tally_rd_miss++;
   check_data("rdata_o", mem_model[LINE_A], got);
   check_data("mem_reads", 4, mem_reads - reads);
   // same line again and served from the cache
   read_word(LINE_A + 1, got);
   tally_rd_hit++;
   check_data("rdata_o", mem_model[LINE_A + 1], got);
   check_data("mem_reads", 4, mem_reads - reads);
   report_result("read miss refill", errs);
endtask

task automatic partial_write_hit();
   int         errs;
   int         writes;
   word_addr_t a;
   fe_data_t   expected;
   fe_data_t   got;
   errs     = error_count;
   writes   = mem_writes;
   a        = LINE_A + 2;
   expected = merge_bytes(mem_model[a], WR_DATA_HIT, 4'b0101);
   write_word(a, WR_DATA_HIT, 4'b0101);
   tally_wr_hit++;
   read_word(a, got);
   tally_rd_hit++;
   check_data("rdata_o", expected, got);
   wait_for_writes(writes + 1);
   check_data("be_addr_o", fe_data_t'(a) << NBYTES_W, last_wr_addr);
   check_data("be_wdata_o", WR_DATA_HIT, last_wr_data);
   check_data("be_wstrb_o", 4'b0101, last_wr_strb);
   report_result("partial write hit", errs);
endtask

task automatic write_miss_no_allocate();
   int       errs;
   int       writes;
   int       reads;
   fe_data_t expected;
   fe_data_t got;
   errs     = error_count;
   writes   = mem_writes;
   expected = merge_bytes(mem_model[MISS_ADDR], WR_DATA_MISS, 4'b1100);
   write_word(MISS_ADDR, WR_DATA_MISS, 4'b1100);
   tally_wr_miss++;
   wait_for_writes(writes + 1);
   check_data("be_addr_o", fe_data_t'(MISS_ADDR) << NBYTES_W, last_wr_addr);
   check_data("be_wdata_o", WR_DATA_MISS, last_wr_data);
   check_data("be_wstrb_o", 4'b1100, last_wr_strb);
   // no allocation so the read has to refill
   reads = mem_reads;
   read_word(MISS_ADDR, got);
   tally_rd_miss++;
   check_data("rdata_o", expected, got);
   check_data("mem_reads", 4, mem_reads - reads);
   report_result("write miss no allocate", errs);
endtask

task automatic counter_readback();
   int       errs;
   fe_data_t got;
   errs = error_count;
   compare_counters();
   read_ctrl(REG_WTB_EMPTY, got);
   check_data("rdata_o (REG_WTB_EMPTY)", 1, got);
   report_result("counter readback", errs);
endtask

task automatic invalidation();
   int       errs;
   int       reads;
   fe_data_t got;
   errs = error_count;
   write_ctrl(REG_INVALIDATE);
   tally_rd_hit  = 0;
   tally_rd_miss = 0;
   tally_wr_hit  = 0;
   tally_wr_miss = 0;
   compare_counters();
   reads = mem_reads;
   read_word(LINE_A + 1, got);
   tally_rd_miss++;
   check_data("rdata_o", mem_model[LINE_A + 1], got);
   check_data("mem_reads", 4, mem_reads - reads);
   // chain input from a neighbouring cache
   @(posedge clk);
   invalidate_in <= 1'b1;
   @(negedge clk);
   check_flag("invalidate_o", 1'b1, invalidate_out);
   @(posedge clk);
   invalidate_in <= 1'b0;
   @(negedge clk);
   check_flag("invalidate_o", 1'b0, invalidate_out);
   reads = mem_reads;
   read_word(LINE_A + 1, got);
   tally_rd_miss++;
   check_data("rdata_o", mem_model[LINE_A + 1], got);
   check_data("mem_reads", 4, mem_reads - reads);
   compare_counters();
   report_result("invalidation", errs);
endtask

/* tests/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb
   import cache_pkg::*;
();

   localparam int         REQ_TIMEOUT  = 200;
   localparam int         DELAY_COUNT  = 64;
   localparam word_addr_t LINE_A       = 14'h0040;
   localparam word_addr_t MISS_ADDR    = 14'h0095;
   localparam fe_data_t   WR_DATA_HIT  = 32'hdead_beef;
   localparam fe_data_t   WR_DATA_MISS = 32'h1234_5678;

   logic                 clk = 1'b0;
   logic                 rst_n;
   logic                 req;
   fe_req_addr_t         addr;
   fe_data_t             wdata;
   fe_strb_t             wstrb;
   fe_data_t             rdata;
   logic                 ack;
   logic                 be_req;
   logic [FE_ADDR_W-1:0] be_addr;
   fe_data_t             be_wdata;
   fe_strb_t             be_wstrb;
   fe_data_t             be_rdata = '0;
   logic                 be_ack = 1'b0;
   logic                 invalidate_in;
   logic                 invalidate_out;
   logic                 wtb_empty_in;
   logic                 wtb_empty_out;

   // memory model state
   fe_data_t             mem_model [2**(FE_ADDR_W-NBYTES_W)];
   int                   delay_table [DELAY_COUNT];
   int                   delay_idx;
   int                   mem_reads;
   int                   mem_writes;
   int                   mem_delay;
   logic                 mem_busy = 1'b0;
   logic [FE_ADDR_W-1:0] last_wr_addr;
   fe_data_t             last_wr_data;
   fe_strb_t             last_wr_strb;

   // scoreboard
   int check_count;
   int error_count;
   int tally_rd_hit;
   int tally_rd_miss;
   int tally_wr_hit;
   int tally_wr_miss;

   `include "cache_tb_tasks.svh"

   always #20 clk = ~clk;

   cache_top UUT (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .req_i        (req),
      .addr_i       (addr),
      .wdata_i      (wdata),
      .wstrb_i      (wstrb),
      .rdata_o      (rdata),
      .ack_o        (ack),
      .be_req_o     (be_req),
      .be_addr_o    (be_addr),
      .be_wdata_o   (be_wdata),
      .be_wstrb_o   (be_wstrb),
      .be_rdata_i   (be_rdata),
      .be_ack_i     (be_ack),
      .invalidate_i (invalidate_in),
      .invalidate_o (invalidate_out),
      .wtb_empty_i  (wtb_empty_in),
      .wtb_empty_o  (wtb_empty_out)
   );

   // slow memory that answers each held request after 1 to 4 cycles
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         be_ack    <= 1'b0;
         mem_busy  <= 1'b0;
         mem_delay <= 0;
         delay_idx <= 0;
      end else begin
         be_ack <= 1'b0;
         if (be_req && !be_ack && !mem_busy) begin
            mem_busy  <= 1'b1;
            mem_delay <= delay_table[delay_idx % DELAY_COUNT];
            delay_idx <= delay_idx + 1;
         end else if (mem_busy && mem_delay != 0) begin
            mem_delay <= mem_delay - 1;
         end else if (mem_busy) begin
            mem_busy <= 1'b0;
            be_ack   <= 1'b1;
            if (|be_wstrb) begin
               mem_model[be_addr[FE_ADDR_W-1:NBYTES_W]] =
                  merge_bytes(mem_model[be_addr[FE_ADDR_W-1:NBYTES_W]], be_wdata, be_wstrb);
               last_wr_addr = be_addr;
               last_wr_data = be_wdata;
               last_wr_strb = be_wstrb;
               mem_writes++;
            end else begin
               be_rdata <= mem_model[be_addr[FE_ADDR_W-1:NBYTES_W]];
               mem_reads++;
            end
         end
      end
   end

   initial begin
      void'($urandom(32'h8ba6));
      rst_n         = 1'b0;
      req           = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      invalidate_in = 1'b0;
      wtb_empty_in  = 1'b1;
      // fill pattern built from the whole word address
      for (int i = 0; i < 2**(FE_ADDR_W-NBYTES_W); i++) begin
         mem_model[i] = {2'b10, i[13:0], ~i[13:0], 2'b01};
      end
      // extra memory latency per transaction, 0 to 3 cycles
      for (int i = 0; i < DELAY_COUNT; i++) begin
         delay_table[i] = $urandom % 4;
      end
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      reset_values();
      read_miss_refill();
      partial_write_hit();
      write_miss_no_allocate();
      counter_readback();
      invalidation();

      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* list.f */
+incdir+tests
verilog/cache_pkg.sv
verilog/cache_front_end.sv
verilog/cache_memory.sv
verilog/cache_write_buffer.sv
verilog/cache_back_end.sv
verilog/cache_control.sv
verilog/cache_top.sv
tests/cache_tb.sv

/* Bender.yml */
package:
  name: cache

sources:
  - files:
      - verilog/cache_pkg.sv
      - verilog/cache_front_end.sv
      - verilog/cache_memory.sv
      - verilog/cache_write_buffer.sv
      - verilog/cache_back_end.sv
      - verilog/cache_control.sv
      - verilog/cache_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cache_tb.sv
